// ==== Makefile ====
# Verilator flow for the register bank

VERILATOR ?= verilator
TOP ?= regBankTb
FILELIST ?= regBank.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
LINTFLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== regBank.f ====
source/regBankPkg.sv
source/gprFile.sv
source/ctrlRegFile.sv
source/readPortMux.sv
source/regBank.sv
tests/regBankTb.sv

// ==== source/ctrlRegFile.sv ====
/*
 Control registers and their shadow copies
 SR bank bit tracking and the bank swap strobe
 Co writes, Ro write to SP and per-cycle exNext loads
 */
`timescale 1ns/1ps

module ctrlRegFile (
	input logic clock,
	input logic reset,
	input regBankPkg::word_t srVal,
	input logic exHold,
	input regBankPkg::ctrlRegs_t exNext,
	input regBankPkg::regWrite_t coWrite,
	input regBankPkg::regWrite_t roWrite,
	output regBankPkg::ctrlRegs_t ctrlOut,
	output regBankPkg::shadowRegs_t shadow,
	output logic bankSwap
);
	import regBankPkg::*;

	logic bankSel; // Bank bit seen on the previous edge

	function automatic logic isId(regId_t id, logic [2:0] grp, logic [3:0] idx);
		return (id.parts.grp == grp) && (id.parts.idx == idx);
	endfunction

	assign bankSwap = srVal[srBankBit] ^ bankSel;

	// Tracks SR through reset so no swap fires on reset release
	always_ff @(posedge clock)
	begin
		bankSel <= srVal[srBankBit];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ctrlOut <= '0;
			shadow <= '0;
		end
		else if (bankSwap)
		begin
			// Live set from shadows while VBR stays put
			ctrlOut.sp <= shadow.ssp;
			ctrlOut.pc <= shadow.spc;
			ctrlOut.pr <= shadow.spr;
			ctrlOut.sr <= shadow.ssr;
			ctrlOut.dlr <= shadow.sdl;
			ctrlOut.dhr <= shadow.sdh;
			ctrlOut.gbr <= shadow.sgb;
			ctrlOut.tbr <= shadow.stb;

			// Outgoing state parked from the execute stage
			shadow.spc <= exNext.pc;
			shadow.spr <= exNext.pr;
			shadow.ssr <= exNext.sr;
			shadow.ssp <= exNext.sp;
			shadow.sdl <= exNext.dlr;
			shadow.sdh <= exNext.dhr;
			shadow.sgb <= exNext.gbr;
			shadow.stb <= exNext.tbr;
		end
		else if (!exHold)
		begin
			ctrlOut.sp <= isId(roWrite.id, grpGpr, idxR15) ? roWrite.value : exNext.sp;
			ctrlOut.pc <= isId(coWrite.id, grpCtrl, idxPc) ? coWrite.value : exNext.pc;
			ctrlOut.pr <= isId(coWrite.id, grpCtrl, idxLr) ? coWrite.value : exNext.pr;
			ctrlOut.sr <= isId(coWrite.id, grpCtrl, idxSr) ? coWrite.value : exNext.sr;
			ctrlOut.vbr <= isId(coWrite.id, grpCtrl, idxVbr) ? coWrite.value : exNext.vbr;
			ctrlOut.dlr <= isId(coWrite.id, grpGpr, idxR0) ? coWrite.value : exNext.dlr; // Via R0
			ctrlOut.dhr <= isId(coWrite.id, grpGpr, idxR1) ? coWrite.value : exNext.dhr; // Via R1
			ctrlOut.gbr <= isId(coWrite.id, grpCtrl, idxGbr) ? coWrite.value : exNext.gbr;
			ctrlOut.tbr <= isId(coWrite.id, grpCtrl, idxTbr) ? coWrite.value : exNext.tbr;

			if (coWrite.id.parts.grp == grpBankB)
			begin
				case (coWrite.id.parts.idx)
					idxR0: shadow.sdl <= coWrite.value; // R0B
					idxR1: shadow.sdh <= coWrite.value; // R1B
					idxSpc: shadow.spc <= coWrite.value;
					idxSlr: shadow.spr <= coWrite.value;
					idxSsr: shadow.ssr <= coWrite.value;
					idxSsp: shadow.ssp <= coWrite.value;
					idxSgb: shadow.sgb <= coWrite.value;
					idxStb: shadow.stb <= coWrite.value;
					default: ; // R2B to R7B belong to the GPR file
				endcase
			end
		end
	end

	// An unknown bank bit would leave the swap strobe unknown
	bankBitKnown: assert property (@(posedge clock)
		!reset |-> !$isunknown(srVal[srBankBit]))
		else $error("SR bank bit is unknown out of reset");

endmodule

// ==== source/gprFile.sv ====
/*
 General register storage
 R2 to R7 in A and B banks, R8 to R14 unbanked
 Bank swap and the Ro and Co write decode
 */
`timescale 1ns/1ps

module gprFile (
	input logic clock,
	input logic exHold,
	input logic bankSwap,
	input regBankPkg::regWrite_t roWrite,
	input regBankPkg::regWrite_t coWrite,
	output regBankPkg::gprView_t gprs
);
	import regBankPkg::*;

	logic roGpr;
	logic roInA;
	logic roInUpper;
	logic coInB;

	always_comb
	begin
		roGpr = (roWrite.id.parts.grp == grpGpr);
		roInA = roGpr && (roWrite.id.parts.idx >= idxR2) && (roWrite.id.parts.idx <= idxR7);
		roInUpper = roGpr && (roWrite.id.parts.idx >= idxR8)
			&& (roWrite.id.parts.idx <= idxR14);
		// R0B and R1B are the SDL and SDH shadows held in the control file
		coInB = (coWrite.id.parts.grp == grpBankB) && (coWrite.id.parts.idx >= idxR2)
			&& (coWrite.id.parts.idx <= idxR7);
	end

	always_ff @(posedge clock)
	begin
		if (bankSwap)
		begin
			gprs.bankA <= gprs.bankB; // Swap wins over any write this cycle
			gprs.bankB <= gprs.bankA;
		end
		else if (!exHold)
		begin
			if (roInA)
				gprs.bankA[roWrite.id.parts.idx[2:0]] <= roWrite.value;
			if (roInUpper)
				gprs.upper[roWrite.id.parts.idx] <= roWrite.value;

			// Inactive bank only reachable through the control port
			if (coInB)
				gprs.bankB[coWrite.id.parts.idx[2:0]] <= coWrite.value;
		end
	end

	// Ro only targets the GPR group or ZZR when idle
	roTargetsGpr: assert property (@(posedge clock)
		!exHold |-> (roGpr || (roWrite.id.code == idZzr)))
		else $error("Ro write outside the GPR group: %h", roWrite.id.code);

endmodule

// ==== source/readPortMux.sv ====
/*
 One combinational read port of the register bank
 Id decode over GPRs, control, shadows, PC and immediate
 Same-cycle bypass of the Ro write
 */
`timescale 1ns/1ps

module readPortMux (
	input regBankPkg::regId_t readId,
	input regBankPkg::gprView_t gprs,
	input regBankPkg::ctrlRegs_t ctrlCur,
	input regBankPkg::shadowRegs_t shadow,
	input regBankPkg::ctrlRegs_t exNext,
	input regBankPkg::regWrite_t roWrite,
	input logic [regBankPkg::immWidth-1:0] idImm,
	input regBankPkg::word_t idPc,
	output regBankPkg::word_t readVal
);
	import regBankPkg::*;

	word_t decoded;
	word_t nextPc;
	word_t immVal;
	logic roBypass;

	// Low half steps and wraps while the upper half passes
	assign nextPc = {idPc[wordWidth-1:wordWidth/2], idPc[wordWidth/2-1:0] + pcStep};
	assign immVal = {{(wordWidth-immWidth+1){idImm[immWidth-1]}}, idImm[immWidth-2:0]};
	assign roBypass = (readId.code == roWrite.id.code) && (roWrite.id.code != idZzr);

	always_comb
	begin
		decoded = '0; // ZZR and holes in the map
		case (readId.parts.grp)
			grpGpr:
				case (readId.parts.idx) inside
					idxR0: decoded = exNext.dlr;
					idxR1: decoded = exNext.dhr;
					[idxR2:idxR7]: decoded = gprs.bankA[readId.parts.idx[2:0]];
					[idxR8:idxR14]: decoded = gprs.upper[readId.parts.idx];
					idxR15: decoded = exNext.sp;
					default: decoded = '0;
				endcase
			grpCtrl:
				case (readId.parts.idx)
					idxPc: decoded = nextPc;
					idxLr: decoded = exNext.pr; // Execute-stage value rather than the register
					idxSr: decoded = ctrlCur.sr;
					idxVbr: decoded = ctrlCur.vbr;
					idxDlr: decoded = exNext.dlr;
					idxDhr: decoded = exNext.dhr;
					idxGbr: decoded = ctrlCur.gbr;
					idxTbr: decoded = ctrlCur.tbr;
					idxImm: decoded = immVal;
					default: decoded = '0;
				endcase
			grpBankB:
				case (readId.parts.idx) inside
					idxR0: decoded = shadow.sdl;
					idxR1: decoded = shadow.sdh;
					[idxR2:idxR7]: decoded = gprs.bankB[readId.parts.idx[2:0]];
					idxSpc: decoded = shadow.spc;
					idxSlr: decoded = shadow.spr;
					idxSsr: decoded = shadow.ssr;
					idxSsp: decoded = shadow.ssp;
					idxSdl: decoded = shadow.sdl;
					idxSdh: decoded = shadow.sdh;
					idxSgb: decoded = shadow.sgb;
					idxStb: decoded = shadow.stb;
					default: decoded = '0;
				endcase
			default: decoded = '0;
		endcase
	end

	assign readVal = roBypass ? roWrite.value : decoded; // Forward the in-flight Ro write

endmodule

// ==== source/regBank.sv ====
/*
 Register bank top level
 Control file, GPR file and the Rm and Rn read ports
 */
`timescale 1ns/1ps

module regBank (
	input logic clock,
	input logic reset,
	input regBankPkg::regId_t rmId,
	input regBankPkg::regId_t rnId,
	input regBankPkg::regWrite_t roWrite,
	input regBankPkg::regWrite_t coWrite,
	input regBankPkg::word_t srVal,
	input logic exHold,
	input logic [regBankPkg::immWidth-1:0] idImm,
	input regBankPkg::word_t idPc,
	input regBankPkg::ctrlRegs_t exNext,
	output regBankPkg::word_t rmVal,
	output regBankPkg::word_t rnVal,
	output regBankPkg::ctrlRegs_t ctrlOut
);
	import regBankPkg::*;

	shadowRegs_t shadow;
	gprView_t gprs;
	logic bankSwap; // Shared by both files so the swap is atomic

	ctrlRegFile ctrlRegs (
		.clock(clock),
		.reset(reset),
		.srVal(srVal),
		.exHold(exHold),
		.exNext(exNext),
		.coWrite(coWrite),
		.roWrite(roWrite),
		.ctrlOut(ctrlOut),
		.shadow(shadow),
		.bankSwap(bankSwap)
	);

	gprFile gprRegs (
		.clock(clock),
		.exHold(exHold),
		.bankSwap(bankSwap),
		.roWrite(roWrite),
		.coWrite(coWrite),
		.gprs(gprs)
	);

	readPortMux rmPort (
		.readId(rmId),
		.gprs(gprs),
		.ctrlCur(ctrlOut),
		.shadow(shadow),
		.exNext(exNext),
		.roWrite(roWrite),
		.idImm(idImm),
		.idPc(idPc),
		.readVal(rmVal)
	);

	readPortMux rnPort (
		.readId(rnId),
		.gprs(gprs),
		.ctrlCur(ctrlOut),
		.shadow(shadow),
		.exNext(exNext),
		.roWrite(roWrite),
		.idImm(idImm),
		.idPc(idPc),
		.readVal(rnVal)
	);

endmodule

// ==== source/regBankPkg.sv ====
/*
 Register bank shared definitions
 Widths, bank bit, PC step, register id map and the id union
 Control, shadow, GPR view and write-port structs
 */
package regBankPkg;
	localparam int wordWidth = 64;
	localparam int regIdWidth = 7;
	localparam int immWidth = 33;
	localparam int srBankBit = 29; // SR.RB, selects the register bank
	localparam logic [31:0] pcStep = 32'd2;

	// Id groups, upper 3 bits of an id
	localparam logic [2:0] grpGpr = 3'd0;
	localparam logic [2:0] grpCtrl = 3'd2;
	localparam logic [2:0] grpBankB = 3'd3;

	// GPR group, R2 to R7 and R8 to R14 are decoded as ranges
	localparam logic [3:0] idxR0 = 4'd0; // Alias of DLR, R0B aliases SDL
	localparam logic [3:0] idxR1 = 4'd1; // Alias of DHR, R1B aliases SDH
	localparam logic [3:0] idxR2 = 4'd2;
	localparam logic [3:0] idxR7 = 4'd7;
	localparam logic [3:0] idxR8 = 4'd8;
	localparam logic [3:0] idxR14 = 4'd14;
	localparam logic [3:0] idxR15 = 4'd15; // SP

	// Control group
	localparam logic [3:0] idxPc = 4'd0;
	localparam logic [3:0] idxLr = 4'd1;
	localparam logic [3:0] idxSr = 4'd2;
	localparam logic [3:0] idxVbr = 4'd3;
	localparam logic [3:0] idxDlr = 4'd4;
	localparam logic [3:0] idxDhr = 4'd5;
	localparam logic [3:0] idxGbr = 4'd6;
	localparam logic [3:0] idxTbr = 4'd7;
	localparam logic [3:0] idxImm = 4'd14;
	localparam logic [3:0] idxZzr = 4'd15;

	// Bank B group, R0B to R7B sit below these
	localparam logic [3:0] idxSpc = 4'd8;
	localparam logic [3:0] idxSlr = 4'd9;
	localparam logic [3:0] idxSsr = 4'd10;
	localparam logic [3:0] idxSsp = 4'd11;
	localparam logic [3:0] idxSdl = 4'd12;
	localparam logic [3:0] idxSdh = 4'd13;
	localparam logic [3:0] idxSgb = 4'd14;
	localparam logic [3:0] idxStb = 4'd15;

	localparam logic [regIdWidth-1:0] idZzr = {grpCtrl, idxZzr}; // Zero register, writes dropped

	typedef logic [wordWidth-1:0] word_t;

	// Flat code for compares, group and index for decoding
	typedef union packed {
		logic [regIdWidth-1:0] code;
		struct packed {
			logic [2:0] grp;
			logic [3:0] idx;
		} parts;
	} regId_t;

	typedef struct packed {
		word_t sp;
		word_t pc;
		word_t pr; // LR
		word_t sr;
		word_t vbr;
		word_t dlr;
		word_t dhr;
		word_t gbr;
		word_t tbr;
	} ctrlRegs_t;

	typedef struct packed {
		word_t spc;
		word_t spr;
		word_t ssr;
		word_t ssp;
		word_t sdl;
		word_t sdh;
		word_t sgb;
		word_t stb;
	} shadowRegs_t;

	typedef struct packed {
		word_t [7:2] bankA; // R2A to R7A
		word_t [14:8] upper; // R8 to R14, not banked
		word_t [7:2] bankB; // R2B to R7B
	} gprView_t;

	typedef struct packed {
		regId_t id;
		word_t value;
	} regWrite_t;
endpackage

// ==== tests/regBankTb.sv ====
/*
 Directed testbench for the register bank
 Clock, reset, watchdog and tests for writes, control path, hold,
 constant reads and the bank swap, closed by one line of counts
 */
`timescale 1ns/1ps

module regBankTb;
	import regBankPkg::*;

	localparam int clockPeriod = 40;
	localparam int timeoutCycles = 500; // Roughly eight times the test length

	logic clock;
	logic reset;
	regId_t rmId;
	regId_t rnId;
	regWrite_t roWrite;
	regWrite_t coWrite;
	word_t srVal;
	logic exHold;
	logic [immWidth-1:0] idImm;
	word_t idPc;
	ctrlRegs_t exNext;
	word_t rmVal;
	word_t rnVal;
	ctrlRegs_t ctrlOut;

	int errorCount = 0;
	int checkCount = 0;
	word_t gprA [2:14]; // Expected R2 to R14
	word_t gprB [2:7]; // Expected R2B to R7B

	regBank dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(timeoutCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles, the tests did not finish", timeoutCycles);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("Regression failed");
		$finish;
	end

	function automatic regId_t idOf(logic [2:0] grp, logic [3:0] idx);
		regId_t id;
		id.parts.grp = grp;
		id.parts.idx = idx;
		return id;
	endfunction

	function automatic word_t randomWord();
		return {$urandom, $urandom};
	endfunction

	function automatic ctrlRegs_t randomCtrl();
		ctrlRegs_t regs;
		for (int i = 0; i < 18; i++)
			regs[i*32 +: 32] = $urandom;
		return regs;
	endfunction

	// Inputs change just after the edge
	task automatic nextCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic idleWrites();
		roWrite.id = idOf(grpCtrl, idxZzr); // ZZR, dropped by the bank
		roWrite.value = '0;
		coWrite.id = idOf(grpCtrl, idxZzr);
		coWrite.value = '0;
	endtask

	task automatic checkWord(string testName, word_t expected, word_t actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("** Error [%s] expected %h actual %h", testName, expected, actual);
		end
	endtask

	task automatic checkCtrl(string testName, ctrlRegs_t expected);
		checkCount++;
		assert (ctrlOut === expected)
		else
		begin
			errorCount++;
			$display("** Error [%s] expected %h actual %h", testName, expected, ctrlOut);
		end
	endtask

	// Same id on both ports, settles for 1 ns
	task automatic readBoth(string testName, regId_t id, word_t expected);
		rmId = id;
		rnId = id;
		#1;
		checkWord({testName, " Rm"}, expected, rmVal);
		checkWord({testName, " Rn"}, expected, rnVal);
	endtask

	task automatic testWriteRead();
		for (int idx = 2; idx <= 14; idx++)
		begin
			gprA[idx] = randomWord();
			roWrite.id = idOf(grpGpr, idx[3:0]);
			roWrite.value = gprA[idx];
			if (idx <= 7)
			begin
				gprB[idx] = randomWord();
				coWrite.id = idOf(grpBankB, idx[3:0]);
				coWrite.value = gprB[idx];
			end
			else
				coWrite.id = idOf(grpCtrl, idxZzr);
			readBoth("writeRead bypass", roWrite.id, gprA[idx]);
			nextCycle();
		end
		idleWrites();
		for (int idx = 2; idx <= 14; idx++)
		begin
			readBoth("writeRead Ro", idOf(grpGpr, idx[3:0]), gprA[idx]);
			if (idx <= 7)
				readBoth("writeRead Co", idOf(grpBankB, idx[3:0]), gprB[idx]);
			nextCycle();
		end
	endtask

	task automatic testControlPath();
		ctrlRegs_t expected;
		word_t value;
		for (int target = 0; target < 4; target++)
		begin
			exNext = randomCtrl();
			expected = exNext;
			value = randomWord();
			coWrite.value = value;
			case (target)
				0: coWrite.id = idOf(grpCtrl, idxSr);
				1: coWrite.id = idOf(grpCtrl, idxGbr);
				2: coWrite.id = idOf(grpCtrl, idxTbr);
				default: coWrite.id = idOf(grpGpr, idxR0); // R0 lands in DLR
			endcase
			case (target)
				0: expected.sr = value;
				1: expected.gbr = value;
				2: expected.tbr = value;
				default: expected.dlr = value;
			endcase
			nextCycle();
			checkCtrl("controlPath Co write", expected);
			idleWrites();
			exNext = randomCtrl();
			expected = exNext;
			readBoth("controlPath LR", idOf(grpCtrl, idxLr), exNext.pr);
			nextCycle();
			checkCtrl("controlPath exNext", expected);
		end
	endtask

	task automatic testHold();
		ctrlRegs_t expected;
		expected = exNext; // Loaded on the last unheld edge
		nextCycle();
		exHold = 1'b1;
		for (int i = 0; i < 3; i++)
		begin
			roWrite.id = idOf(grpGpr, 4'd5);
			roWrite.value = randomWord();
			coWrite.id = idOf(grpBankB, 4'd3);
			coWrite.value = randomWord();
			exNext = randomCtrl();
			nextCycle();
			checkCtrl("hold ctrlOut", expected);
		end
		idleWrites();
		readBoth("hold R5", idOf(grpGpr, 4'd5), gprA[5]);
		readBoth("hold R3B", idOf(grpBankB, 4'd3), gprB[3]);
		exHold = 1'b0;
		expected = exNext;
		nextCycle();
		checkCtrl("hold release", expected);
	endtask

	task automatic testConstants();
		idPc = 64'h1234_5678_0000_1000;
		readBoth("constants PC", idOf(grpCtrl, idxPc), 64'h1234_5678_0000_1002);
		idPc = 64'h8765_4321_ffff_ffff; // Low half wraps, upper half untouched
		readBoth("constants PC wrap", idOf(grpCtrl, idxPc), 64'h8765_4321_0000_0001);
		idImm = 33'h1_0000_0005;
		readBoth("constants IMM negative", idOf(grpCtrl, idxImm), 64'hffff_ffff_0000_0005);
		idImm = 33'h0_8000_0000;
		readBoth("constants IMM positive", idOf(grpCtrl, idxImm), 64'h0000_0000_8000_0000);
		readBoth("constants ZZR", idOf(grpCtrl, idxZzr), '0);
		readBoth("constants unmapped group", idOf(3'd1, 4'd4), '0);
		readBoth("constants unmapped index", idOf(grpCtrl, 4'd9), '0);
		nextCycle();
	endtask

	task automatic testBankSwap();
		ctrlRegs_t swapNext;
		word_t sgbVal;
		for (int idx = 2; idx <= 7; idx++)
		begin
			gprA[idx] = randomWord();
			gprB[idx] = randomWord();
			roWrite.id = idOf(grpGpr, idx[3:0]);
			roWrite.value = gprA[idx];
			coWrite.id = idOf(grpBankB, idx[3:0]);
			coWrite.value = gprB[idx];
			nextCycle();
		end
		idleWrites();
		sgbVal = randomWord();
		coWrite.id = idOf(grpBankB, idxSgb);
		coWrite.value = sgbVal;
		nextCycle();
		idleWrites();
		swapNext = randomCtrl();
		exNext = swapNext;
		srVal[srBankBit] = 1'b1; // Swap on the next edge
		nextCycle();
		for (int idx = 2; idx <= 7; idx++)
		begin
			readBoth("bankSwap A side", idOf(grpGpr, idx[3:0]), gprB[idx]);
			readBoth("bankSwap B side", idOf(grpBankB, idx[3:0]), gprA[idx]);
		end
		checkWord("bankSwap GBR", sgbVal, ctrlOut.gbr);
		readBoth("bankSwap SGB", idOf(grpBankB, idxSgb), swapNext.gbr);
		readBoth("bankSwap SPC", idOf(grpBankB, idxSpc), swapNext.pc);
		readBoth("bankSwap SSR", idOf(grpBankB, idxSsr), swapNext.sr);
		srVal[srBankBit] = 1'b0;
		nextCycle();
		for (int idx = 2; idx <= 7; idx++)
			readBoth("bankSwap back", idOf(grpGpr, idx[3:0]), gprA[idx]);
	endtask

	initial
	begin
		void'($urandom(32'hebc));
		reset = 1'b1;
		exHold = 1'b0;
		srVal = '0;
		idImm = '0;
		idPc = '0;
		exNext = '0;
		rmId = idOf(grpCtrl, idxZzr);
		rnId = idOf(grpCtrl, idxZzr);
		idleWrites();
		repeat (8) nextCycle();
		reset = 1'b0;
		testWriteRead();
		testControlPath();
		testHold();
		testConstants();
		testBankSwap();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
